// File: common/smartnic_defines.svh
`ifndef SMARTNIC_DEFINES_SVH
`define SMARTNIC_DEFINES_SVH

// stream geometry.
`define NUM_PORTS      2             // ingress ports, each with an out and a c2h path.
`define DATA_BYTE_WID  8             // bytes per stream beat.
`define TID_WID        2             // stream id bits.
`define TDEST_WID      4             // destination bits, one port code.
`define TUSER_WID      1             // sideband user bits.

// axi4-lite geometry.
`define AXIL_ADDR_WID  32            // byte address.
`define AXIL_DATA_WID  32            // one register word.
`define AXIL_STRB_WID  4             // one strobe per data byte.

// register map, byte offsets.
`define REG_CONFIG     32'h00        // app_igr config word.
`define REG_STATS_BASE 32'h10        // port i out count at +8*i, c2h count at +8*i+4.
`define REG_STATS_STEP 8             // byte stride between ports.
`define REG_C2H_OFFSET 4             // c2h count sits one word above out count.

`endif // SMARTNIC_DEFINES_SVH

// File: common/smartnic_pkg.sv
`include "smartnic_defines.svh"

package smartnic_pkg;

    // kind of endpoint a port code refers to.
    typedef enum logic [1:0] {
        PHY = 2'b00,                 // physical network port.
        PF  = 2'b01,                 // host physical function.
        VF0 = 2'b10,                 // first virtual function, host bound.
        VF1 = 2'b11                  // second virtual function.
    } port_typ_t;

    // structured view of a destination code.
    typedef struct packed {
        port_typ_t  typ;             // endpoint kind, upper bits.
        logic [1:0] num;             // endpoint index within that kind.
    } port_encoded_t;

    // one tdest word, seen either as plain bits or as type plus number.
    typedef union packed {
        logic [`TDEST_WID-1:0] raw;  // bits as carried on the stream.
        port_encoded_t         encoded; // decoded for steering.
    } port_t;

    // config register layout.
    typedef struct packed {
        logic [30:0] rsvd;           // reserved, always zero.
        logic        demux_sel;      // 1 forces every packet to c2h.
    } app_igr_config_t;

    // path index used by the port steering logic.
    localparam int PATH_OUT = 0;     // normal egress stream.
    localparam int PATH_C2H = 1;     // host bound stream.
    localparam int NUM_PATHS = 2;

endpackage : smartnic_pkg

// File: common/axi_pkg.sv
`include "smartnic_defines.svh"

package axi_pkg;

    import smartnic_pkg::*;

    // one axi4-stream beat; valid and ready travel beside it.
    typedef struct packed {
        logic [`DATA_BYTE_WID*8-1:0] tdata;  // payload.
        logic [`DATA_BYTE_WID-1:0]   tkeep;  // byte enables.
        logic                        tlast;  // last beat of a packet.
        logic [`TID_WID-1:0]         tid;    // stream id.
        port_t                       tdest;  // destination port code.
        logic [`TUSER_WID-1:0]       tuser;  // sideband.
    } axi4s_t;

    // axi4-lite manager to subordinate signals.
    typedef struct packed {
        logic [`AXIL_ADDR_WID-1:0] awaddr;   // write address.
        logic                      awvalid;
        logic [`AXIL_DATA_WID-1:0] wdata;    // write data.
        logic [`AXIL_STRB_WID-1:0] wstrb;    // byte strobes.
        logic                      wvalid;
        logic                      bready;   // write response accept.
        logic [`AXIL_ADDR_WID-1:0] araddr;   // read address.
        logic                      arvalid;
        logic                      rready;   // read data accept.
    } axil_req_t;

    // axi4-lite subordinate to manager signals.
    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic [1:0]                bresp;    // write status.
        logic                      bvalid;
        logic                      arready;
        logic [`AXIL_DATA_WID-1:0] rdata;    // read data.
        logic [1:0]                rresp;    // read status.
        logic                      rvalid;
    } axil_resp_t;

    // response codes.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10; // not returned by this block.

endpackage : axi_pkg

// File: app_igr_reg/app_igr_reg_blk.sv
`timescale 1ns/1ps

`include "smartnic_defines.svh"

module app_igr_reg_blk
    import smartnic_pkg::*, axi_pkg::*;
(
    input  logic            core_clk,
    input  logic            reset,

    input  axil_req_t       axil_req,
    output axil_resp_t      axil_resp,

    input  logic [31:0]     out_count [`NUM_PORTS],  // packets sent on out, per port.
    input  logic [31:0]     c2h_count [`NUM_PORTS],  // packets sent on c2h, per port.

    output app_igr_config_t app_igr_config
);

    logic                      aw_pending;            // address held, data not yet seen.
    logic [`AXIL_ADDR_WID-1:0] aw_addr_q;
    logic                      w_pending;             // data held, address not yet seen.
    logic [`AXIL_DATA_WID-1:0] w_data_q;
    logic [`AXIL_STRB_WID-1:0] w_strb_q;

    logic                      aw_hs;
    logic                      w_hs;
    logic                      ar_hs;
    logic                      do_write;
    logic [`AXIL_ADDR_WID-1:0] wr_addr;
    logic [`AXIL_DATA_WID-1:0] wr_data;
    logic [`AXIL_STRB_WID-1:0] wr_strb;

    logic                      bvalid;
    logic                      rvalid;
    logic [`AXIL_DATA_WID-1:0] rdata;
    logic [`AXIL_DATA_WID-1:0] rd_mux;

    // each channel is taken once per transaction and then blocked until the response leaves.
    assign axil_resp.awready = !aw_pending && !bvalid;
    assign axil_resp.wready  = !w_pending && !bvalid;
    assign axil_resp.arready = !rvalid;              // one read in flight.
    assign axil_resp.bvalid  = bvalid;
    assign axil_resp.bresp   = RESP_OKAY;
    assign axil_resp.rvalid  = rvalid;
    assign axil_resp.rdata   = rdata;
    assign axil_resp.rresp   = RESP_OKAY;            // unmapped reads return zero, still okay.

    assign aw_hs = axil_req.awvalid && axil_resp.awready;
    assign w_hs  = axil_req.wvalid && axil_resp.wready;
    assign ar_hs = axil_req.arvalid && axil_resp.arready;

    // the write fires in the cycle where the later of the two channels arrives.
    assign do_write = (aw_pending || aw_hs) && (w_pending || w_hs) && !bvalid;
    assign wr_addr  = aw_pending ? aw_addr_q : axil_req.awaddr;
    assign wr_data  = w_pending ? w_data_q : axil_req.wdata;
    assign wr_strb  = w_pending ? w_strb_q : axil_req.wstrb;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            aw_pending     <= 1'b0;
            w_pending      <= 1'b0;
            bvalid         <= 1'b0;
            app_igr_config <= '0;                    // reserved bits stay zero from here.
        end else begin
            if (do_write) begin
                aw_pending <= 1'b0;
                w_pending  <= 1'b0;
                bvalid     <= 1'b1;                  // response one cycle after acceptance.
                if (wr_addr == `REG_CONFIG && wr_strb[0]) begin
                    app_igr_config.demux_sel <= wr_data[0]; // only byte 0 holds state.
                end
            end else begin
                if (aw_hs) aw_pending <= 1'b1;
                if (w_hs)  w_pending  <= 1'b1;
                if (bvalid && axil_req.bready) bvalid <= 1'b0;
            end
        end
    end

    // channel holding registers.
    always_ff @(posedge core_clk) begin
        if (aw_hs) aw_addr_q <= axil_req.awaddr;
        if (w_hs) begin
            w_data_q <= axil_req.wdata;
            w_strb_q <= axil_req.wstrb;
        end
    end

    // read decode, config word or one of the packet counters.
    always_comb begin
        rd_mux = '0;                                 // unmapped.
        if (axil_req.araddr == `REG_CONFIG) rd_mux = app_igr_config;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (axil_req.araddr == 32'(`REG_STATS_BASE + `REG_STATS_STEP*i)) begin
                rd_mux = out_count[i];
            end
            if (axil_req.araddr == 32'(`REG_STATS_BASE + `REG_STATS_STEP*i + `REG_C2H_OFFSET)) begin
                rd_mux = c2h_count[i];
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (ar_hs) begin
            rvalid <= 1'b1;                          // data one cycle after arvalid.
        end else if (rvalid && axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (ar_hs) rdata <= rd_mux;                  // held until rready.
    end

endmodule : app_igr_reg_blk

// File: app_igr_port/app_igr_port.sv
`timescale 1ns/1ps

module app_igr_port
    import smartnic_pkg::*, axi_pkg::*;
(
    input  logic            core_clk,
    input  logic            reset,

    input  app_igr_config_t app_igr_config,

    input  axi4s_t          in_beat,
    input  logic            in_valid,
    output logic            in_ready,

    output axi4s_t          out_beat,
    output logic            out_valid,
    input  logic            out_ready,

    output axi4s_t          c2h_beat,
    output logic            c2h_valid,
    input  logic            c2h_ready
);

    axi4s_t     slot  [NUM_PATHS][2];  // [path][0] drives the output, [1] is the skid.
    logic [1:0] cnt   [NUM_PATHS];     // beats held per path, 0 to 2.
    logic       vld   [NUM_PATHS];
    logic       rdy   [NUM_PATHS];     // downstream ready per path.
    logic       space [NUM_PATHS];     // path can take a beat this cycle.
    logic       push  [NUM_PATHS];
    logic       pop   [NUM_PATHS];
    logic       sel_c2h;               // steering decision for the current beat.

    // host bound when the destination is vf0 or the config forces it.
    assign sel_c2h = (in_beat.tdest.encoded.typ == VF0) || app_igr_config.demux_sel;

    assign rdy[PATH_OUT] = out_ready;
    assign rdy[PATH_C2H] = c2h_ready;

    // ready comes from the selected path only.
    assign in_ready = sel_c2h ? space[PATH_C2H] : space[PATH_OUT];

    always_comb begin
        for (int p = 0; p < NUM_PATHS; p++) begin
            vld[p]   = (cnt[p] != 2'd0);
            space[p] = (cnt[p] != 2'd2);          // from registers only, no path from rdy.
            pop[p]   = vld[p] && rdy[p];
            push[p]  = in_valid && in_ready && (sel_c2h == (p == PATH_C2H));
        end
    end

    // occupancy per path.
    always_ff @(posedge core_clk) begin
        if (reset) begin
            for (int p = 0; p < NUM_PATHS; p++) cnt[p] <= 2'd0;
        end else begin
            for (int p = 0; p < NUM_PATHS; p++) begin
                if (push[p] && !pop[p]) cnt[p] <= cnt[p] + 2'd1;
                else if (pop[p] && !push[p]) cnt[p] <= cnt[p] - 2'd1;
            end
        end
    end

    // beat storage; the head is refilled from the skid or straight from the input.
    always_ff @(posedge core_clk) begin
        for (int p = 0; p < NUM_PATHS; p++) begin
            case ({push[p], pop[p]})
                2'b10: begin
                    if (cnt[p] == 2'd0) slot[p][0] <= in_beat;
                    else slot[p][1] <= in_beat;   // head busy, park in the skid.
                end
                2'b01: slot[p][0] <= slot[p][1]; // skid moves up.
                2'b11: begin
                    if (cnt[p] == 2'd1) slot[p][0] <= in_beat; // pass through.
                    else begin
                        slot[p][0] <= slot[p][1];
                        slot[p][1] <= in_beat;
                    end
                end
                default: ;
            endcase
        end
    end

    assign out_beat  = slot[PATH_OUT][0];
    assign out_valid = vld[PATH_OUT];
    assign c2h_beat  = slot[PATH_C2H][0];
    assign c2h_valid = vld[PATH_C2H];

endmodule : app_igr_port

// File: verilog/app_igr_stats.sv
`timescale 1ns/1ps

`include "smartnic_defines.svh"

module app_igr_stats #(
    parameter int CNT_WID = 32                     // counter width, wraps at the top.
) (
    input  logic                  core_clk,
    input  logic                  reset,

    input  logic [`NUM_PORTS-1:0] out_valid,
    input  logic [`NUM_PORTS-1:0] out_ready,
    input  logic [`NUM_PORTS-1:0] out_tlast,

    input  logic [`NUM_PORTS-1:0] c2h_valid,
    input  logic [`NUM_PORTS-1:0] c2h_ready,
    input  logic [`NUM_PORTS-1:0] c2h_tlast,

    output logic [CNT_WID-1:0]    out_count [`NUM_PORTS],
    output logic [CNT_WID-1:0]    c2h_count [`NUM_PORTS]
);

    logic [`NUM_PORTS-1:0] out_eop;                  // packet completed on out.
    logic [`NUM_PORTS-1:0] c2h_eop;                  // packet completed on c2h.

    // a packet counts once its last beat is accepted downstream.
    assign out_eop = out_valid & out_ready & out_tlast;
    assign c2h_eop = c2h_valid & c2h_ready & c2h_tlast;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                out_count[i] <= '0;
                c2h_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (out_eop[i]) out_count[i] <= out_count[i] + 1'b1; // wraps.
                if (c2h_eop[i]) c2h_count[i] <= c2h_count[i] + 1'b1;
            end
        end
    end

endmodule : app_igr_stats

// File: verilog/smartnic_app_igr.sv
`timescale 1ns/1ps

`include "smartnic_defines.svh"

module smartnic_app_igr
    import smartnic_pkg::*, axi_pkg::*;
(
    input  logic                  core_clk,
    input  logic                  reset,

    input  axil_req_t             axil_req,
    output axil_resp_t            axil_resp,

    input  axi4s_t                in_beat   [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] in_valid,
    output logic [`NUM_PORTS-1:0] in_ready,

    output axi4s_t                out_beat  [`NUM_PORTS],
    output logic [`NUM_PORTS-1:0] out_valid,
    input  logic [`NUM_PORTS-1:0] out_ready,

    output axi4s_t                c2h_beat  [`NUM_PORTS],
    output logic [`NUM_PORTS-1:0] c2h_valid,
    input  logic [`NUM_PORTS-1:0] c2h_ready
);

    app_igr_config_t       app_igr_config;            // shared by all ports.
    logic [31:0]           out_count [`NUM_PORTS];
    logic [31:0]           c2h_count [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] out_tlast;
    logic [`NUM_PORTS-1:0] c2h_tlast;

    app_igr_reg_blk u_reg_blk (
        .core_clk       (core_clk),
        .reset          (reset),
        .axil_req       (axil_req),
        .axil_resp      (axil_resp),
        .out_count      (out_count),
        .c2h_count      (c2h_count),
        .app_igr_config (app_igr_config)
    );

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        app_igr_port u_port (
            .core_clk       (core_clk),
            .reset          (reset),
            .app_igr_config (app_igr_config),
            .in_beat        (in_beat[i]),
            .in_valid       (in_valid[i]),
            .in_ready       (in_ready[i]),
            .out_beat       (out_beat[i]),
            .out_valid      (out_valid[i]),
            .out_ready      (out_ready[i]),
            .c2h_beat       (c2h_beat[i]),
            .c2h_valid      (c2h_valid[i]),
            .c2h_ready      (c2h_ready[i])
        );

        assign out_tlast[i] = out_beat[i].tlast;       // snooped by the counters.
        assign c2h_tlast[i] = c2h_beat[i].tlast;
    end : g_port

    app_igr_stats #(
        .CNT_WID (32)
    ) u_stats (
        .core_clk  (core_clk),
        .reset     (reset),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_tlast (out_tlast),
        .c2h_valid (c2h_valid),
        .c2h_ready (c2h_ready),
        .c2h_tlast (c2h_tlast),
        .out_count (out_count),
        .c2h_count (c2h_count)
    );

endmodule : smartnic_app_igr

// File: test/smartnic_app_igr_checker.sv
`timescale 1ns/1ps

`include "smartnic_defines.svh"

module smartnic_app_igr_checker
    import smartnic_pkg::*, axi_pkg::*;
(
    input logic                  core_clk,
    input logic                  reset,
    input axil_req_t             axil_req,
    input axil_resp_t            axil_resp,
    input axi4s_t                out_beat [`NUM_PORTS],
    input logic [`NUM_PORTS-1:0] out_valid,
    input logic [`NUM_PORTS-1:0] out_ready,
    input axi4s_t                c2h_beat [`NUM_PORTS],
    input logic [`NUM_PORTS-1:0] c2h_valid,
    input logic [`NUM_PORTS-1:0] c2h_ready
);

    int fails;                                     // assertion failures so far.

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_stream
        // a stalled beat holds still.
        a_out_hold: assert property (@(posedge core_clk) disable iff (reset)
            out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_beat[i]))
            else begin
                fails++;
                $error("out beat on port %0d changed while stalled", i);
            end
        a_c2h_hold: assert property (@(posedge core_clk) disable iff (reset)
            c2h_valid[i] && !c2h_ready[i] |=> c2h_valid[i] && $stable(c2h_beat[i]))
            else begin
                fails++;
                $error("c2h beat on port %0d changed while stalled", i);
            end
    end : g_stream

    a_b_hold: assert property (@(posedge core_clk) disable iff (reset)
        axil_resp.bvalid && !axil_req.bready |=> axil_resp.bvalid)
        else begin
            fails++;
            $error("bvalid dropped before bready");
        end

    a_r_hold: assert property (@(posedge core_clk) disable iff (reset)
        axil_resp.rvalid && !axil_req.rready |=> axil_resp.rvalid && $stable(axil_resp.rdata))
        else begin
            fails++;
            $error("read response dropped or changed before rready");
        end

    // sync reset, everything quiet one edge later.
    a_reset_quiet: assert property (@(posedge core_clk)
        reset |=> out_valid == '0 && c2h_valid == '0 && !axil_resp.bvalid && !axil_resp.rvalid)
        else begin
            fails++;
            $error("valid output high during reset");
        end

endmodule : smartnic_app_igr_checker

bind smartnic_app_igr smartnic_app_igr_checker chk0 (.*);

// File: test/tb_monitor.sv
`timescale 1ns/1ps

`include "smartnic_defines.svh"

module tb_monitor
    import smartnic_pkg::*, axi_pkg::*;
(
    input  logic                  core_clk,
    input  logic                  reset,
    input  logic                  exp_demux_sel,   // config the DUT should hold.
    input  axi4s_t                in_beat  [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] in_valid,
    input  logic [`NUM_PORTS-1:0] in_ready,
    input  axi4s_t                out_beat [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] out_valid,
    input  logic [`NUM_PORTS-1:0] out_ready,
    input  axi4s_t                c2h_beat [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] c2h_valid,
    input  logic [`NUM_PORTS-1:0] c2h_ready,
    output int                    pass_cnt,
    output int                    fail_cnt,
    output int                    pkt_cnt,          // packets whose last beat left.
    output int                    left_beats        // predicted, not yet seen.
);

    axi4s_t exp_q   [`NUM_PORTS][2][$];            // predicted beats, [port][path].
    bit     pkt_bad [`NUM_PORTS][2];               // current packet saw a wrong beat.

    // c2h when the top two tdest bits give type vf0 (2'b10) or demux_sel forces it.
    function automatic int predicted_path(input axi4s_t beat);
        return (beat.tdest.raw[3:2] == 2'b10 || exp_demux_sel) ? 1 : 0;
    endfunction

    task automatic check_beat(input int p, input int path, input axi4s_t got);
        axi4s_t want;
        string  name;
        name = path ? "c2h" : "out";
        if (exp_q[p][path].size() == 0) begin
            $display("FAILED %0t: port %0d %s beat %h came with none expected",
                     $time, p, name, got);
            pkt_bad[p][path] = 1'b1;
        end else begin
            want = exp_q[p][path].pop_front();
            if (got !== want) begin
                $display("FAILED %0t: port %0d %s beat %h, expected %h", $time, p, name, got, want);
                pkt_bad[p][path] = 1'b1;
            end
        end
        if (got.tlast) begin                        // one line per packet.
            if (pkt_bad[p][path]) fail_cnt++;
            else pass_cnt++;
            $display("packet %0d on port %0d via %s: %s", got.tdata[63:56], p, name,
                     pkt_bad[p][path] ? "wrong" : "ok");
            pkt_bad[p][path] = 1'b0;
            pkt_cnt++;
        end
    endtask

    // handshakes sampled mid cycle, they complete at the next rising edge.
    always @(negedge core_clk) begin
        if (!reset) begin
            left_beats = 0;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (in_valid[p] && in_ready[p])
                    exp_q[p][predicted_path(in_beat[p])].push_back(in_beat[p]);
                if (out_valid[p] && out_ready[p]) check_beat(p, 0, out_beat[p]);
                if (c2h_valid[p] && c2h_ready[p]) check_beat(p, 1, c2h_beat[p]);
                left_beats += exp_q[p][0].size() + exp_q[p][1].size();
            end
        end
    end

endmodule : tb_monitor

// File: test/tb_smartnic_app_igr.sv
`timescale 1ns/1ps

`include "smartnic_defines.svh"

module tb_smartnic_app_igr
    import smartnic_pkg::*, axi_pkg::*;
();

    localparam int NUM_ROWS = 12;

    // one packet of stimulus with the path it must take.
    typedef struct packed {
        logic [7:0] port;                          // ingress port.
        logic [3:0] tdest;                         // raw destination code.
        logic [7:0] len;                           // beats in the packet.
        logic       cfg;                           // demux_sel while it is sent.
        logic       exp_c2h;                       // expected path, 1 for c2h.
    } row_t;

    logic                  core_clk;
    logic                  reset;
    axil_req_t             axil_req;
    axil_resp_t            axil_resp;
    axi4s_t                in_beat  [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] in_valid;
    logic [`NUM_PORTS-1:0] in_ready;
    axi4s_t                out_beat [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] out_valid;
    logic [`NUM_PORTS-1:0] out_ready;
    axi4s_t                c2h_beat [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] c2h_valid;
    logic [`NUM_PORTS-1:0] c2h_ready;

    row_t rows [NUM_ROWS];
    logic exp_demux;                               // config value the DUT holds now.
    int   seed = 77350;
    int   pass_cnt;
    int   fail_cnt;
    int   mon_pass;
    int   mon_fail;
    int   pkt_cnt;                                 // packets whose last beat left.
    int   left_beats;                              // predicted beats still outstanding.
    int   cycle_limit;
    int   cycles;

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;           // 8 ns period.
    end

    smartnic_app_igr dut0 (.*);

    tb_monitor mon0 (.*, .exp_demux_sel(exp_demux), .pass_cnt(mon_pass), .fail_cnt(mon_fail));

    // random back-pressure on every output.
    initial begin
        out_ready = '0;
        c2h_ready = '0;
        forever begin
            @(posedge core_clk);
            #1;
            for (int p = 0; p < `NUM_PORTS; p++) begin
                out_ready[p] = !reset && ($random(seed) % 4 != 0); // ready three cycles in four.
                c2h_ready[p] = !reset && ($random(seed) % 4 != 0);
            end
        end
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge core_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d packets left the DUT",
                 cycles, pkt_cnt, NUM_ROWS);
        $display(">>> FAIL");
        $finish;
    end

    task automatic load_table();
        // port, tdest, beats, demux_sel, expected path.
        rows[0]  = '{8'd0, 4'h0, 8'd3, 1'b0, 1'b0};  // phy, out.
        rows[1]  = '{8'd1, 4'h8, 8'd2, 1'b0, 1'b1};  // vf0, c2h.
        rows[2]  = '{8'd0, 4'h9, 8'd1, 1'b0, 1'b1};  // vf0 number 1.
        rows[3]  = '{8'd1, 4'h5, 8'd4, 1'b0, 1'b0};  // pf.
        rows[4]  = '{8'd0, 4'he, 8'd2, 1'b0, 1'b0};  // vf1 stays on out.
        rows[5]  = '{8'd1, 4'hb, 8'd3, 1'b0, 1'b1};
        rows[6]  = '{8'd0, 4'h0, 8'd2, 1'b1, 1'b1};  // phy forced to c2h.
        rows[7]  = '{8'd1, 4'h6, 8'd3, 1'b1, 1'b1};
        rows[8]  = '{8'd0, 4'hd, 8'd1, 1'b1, 1'b1};
        rows[9]  = '{8'd1, 4'h4, 8'd2, 1'b0, 1'b0};  // rule again.
        rows[10] = '{8'd0, 4'ha, 8'd2, 1'b0, 1'b1};
        rows[11] = '{8'd1, 4'h3, 8'd1, 1'b0, 1'b0};
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got === want) begin
            pass_cnt++;
            $display("%s: ok", what);
        end else begin
            fail_cnt++;
            $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // both channels offered together, each dropped once taken.
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        bit         aw_taken;
        bit         w_taken;
        logic [1:0] resp;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        while (axil_req.awvalid || axil_req.wvalid) begin
            @(negedge core_clk);
            aw_taken = axil_resp.awready;
            w_taken  = axil_resp.wready;
            @(posedge core_clk);
            #1;
            if (aw_taken) axil_req.awvalid = 1'b0;
            if (w_taken) axil_req.wvalid = 1'b0;
        end
        do @(negedge core_clk); while (!axil_resp.bvalid);
        resp = axil_resp.bresp;
        @(posedge core_clk);
        #1;
        axil_req.bready = 1'b0;
        check_value("write response", 32'(resp), 32'h0);  // okay.
    endtask

    task automatic check_reg(input logic [31:0] addr, input logic [31:0] want, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        do @(negedge core_clk); while (!axil_resp.arready);
        @(posedge core_clk);
        #1;
        axil_req.arvalid = 1'b0;
        do @(negedge core_clk); while (!axil_resp.rvalid);
        data = axil_resp.rdata;
        resp = axil_resp.rresp;
        @(posedge core_clk);
        #1;
        axil_req.rready = 1'b0;
        check_value(what, data, want);
        check_value({what, " response"}, 32'(resp), 32'h0);  // okay.
    endtask

    // sends this port's packets among rows lo to hi-1.
    task automatic send_rows(input int p, input int lo, input int hi);
        axi4s_t beat;
        for (int r = lo; r < hi; r++) begin
            if (rows[r].port != p) continue;
            for (int b = 0; b < rows[r].len; b++) begin
                beat.tdata = {8'(r), 8'(b), 16'(p), 32'($random(seed))}; // row and beat on top.
                beat.tkeep = (b == rows[r].len - 1) ? 8'h0f : 8'hff;
                beat.tlast = (b == rows[r].len - 1);
                beat.tid   = 2'(p);
                beat.tdest = rows[r].tdest;
                beat.tuser = 1'(b);
                in_beat[p]  = beat;
                in_valid[p] = 1'b1;
                do @(negedge core_clk); while (!in_ready[p]); // taken at the next edge.
                @(posedge core_clk);
                #1;
            end
        end
        in_valid[p] = 1'b0;
    endtask

    initial begin
        int r;
        int seg_end;
        int exp_out [`NUM_PORTS];
        int exp_c2h [`NUM_PORTS];
        reset     = 1'b1;
        axil_req  = '0;
        in_valid  = '0;
        exp_demux = 1'b0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            in_beat[p] = '0;
            exp_out[p] = 0;
            exp_c2h[p] = 0;
        end
        load_table();
        r = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r += rows[i].len;
            if (rows[i].exp_c2h) exp_c2h[rows[i].port]++;
            else exp_out[rows[i].port]++;
        end
        cycle_limit = r * 4 + 200;                 // four cycles a beat plus register traffic.
        repeat (3) @(posedge core_clk);
        #1 reset = 1'b0;
        @(negedge core_clk);
        check_value("stream valids after reset", {out_valid, c2h_valid}, 0);
        @(posedge core_clk);
        #1;
        check_reg(`REG_CONFIG, 0, "config after reset");
        for (int p = 0; p < `NUM_PORTS; p++) begin
            check_reg(`REG_STATS_BASE + `REG_STATS_STEP*p, 0,
                      $sformatf("port %0d out count after reset", p));
            check_reg(`REG_STATS_BASE + `REG_STATS_STEP*p + `REG_C2H_OFFSET, 0,
                      $sformatf("port %0d c2h count after reset", p));
        end
        // rows with the same config run as one segment, ports in parallel.
        r = 0;
        while (r < NUM_ROWS) begin
            seg_end = r;
            while (seg_end < NUM_ROWS && rows[seg_end].cfg == rows[r].cfg) seg_end++;
            if (rows[r].cfg != exp_demux) begin
                axil_write(`REG_CONFIG, {31'd0, rows[r].cfg});
                exp_demux = rows[r].cfg;           // applies from the cycle after bvalid.
                check_reg(`REG_CONFIG, {31'd0, rows[r].cfg}, "config readback");
            end
            for (int p = 0; p < `NUM_PORTS; p++) begin
                fork
                    automatic int pp = p;
                    send_rows(pp, r, seg_end);
                join_none
            end
            wait fork;
            r = seg_end;
        end
        wait (pkt_cnt == NUM_ROWS);
        @(posedge core_clk);
        #1;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            check_reg(`REG_STATS_BASE + `REG_STATS_STEP*p, exp_out[p],
                      $sformatf("port %0d out count", p));
            check_reg(`REG_STATS_BASE + `REG_STATS_STEP*p + `REG_C2H_OFFSET, exp_c2h[p],
                      $sformatf("port %0d c2h count", p));
        end
        if (left_beats != 0) begin
            fail_cnt++;
            $display("%0d predicted beats never left the DUT", left_beats);
        end
        if (dut0.chk0.fails != 0) begin
            fail_cnt++;
            $display("checker assertions failed %0d times", dut0.chk0.fails);
        end
        $display("tests passed %0d, failed %0d", pass_cnt + mon_pass, fail_cnt + mon_fail);
        if (fail_cnt + mon_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_smartnic_app_igr

// File: all.f
+incdir+common
common/smartnic_pkg.sv
common/axi_pkg.sv
app_igr_reg/app_igr_reg_blk.sv
app_igr_port/app_igr_port.sv
verilog/app_igr_stats.sv
verilog/smartnic_app_igr.sv
test/smartnic_app_igr_checker.sv
test/tb_monitor.sv
test/tb_smartnic_app_igr.sv

// File: Bender.yml
package:
  name: smartnic_app_igr

sources:
  - include_dirs:
      - common
    files:
      - common/smartnic_pkg.sv
      - common/axi_pkg.sv
      - app_igr_reg/app_igr_reg_blk.sv
      - app_igr_port/app_igr_port.sv
      - verilog/app_igr_stats.sv
      - verilog/smartnic_app_igr.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/smartnic_app_igr_checker.sv
      - test/tb_monitor.sv
      - test/tb_smartnic_app_igr.sv
